/* Bender.yml */
package:
  name: uart_debug_unit

sources:
  - files:
      - common/debug_pkg.sv
      - hw/loader/instr_loader.sv
      - hw/dump/dump_serializer.sv
      - hw/debug_ctrl.sv
      - hw/debug_unit_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_debug_unit.sv

/* common/debug_pkg.sv */
package debug_pkg;

    // basic widths
    localparam int NB_BYTE     = 8;
    localparam int NB_WORD     = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int NB_OPCODE   = 6;   // also funct
    localparam int NB_IMM      = 16;
    localparam int NB_SEL      = 2;   // alu_src, width, alu_op, forwarding
    localparam int NB_MEM_ADDR = 8;

    typedef logic [NB_BYTE-1:0] byte_t;
    typedef logic [NB_WORD-1:0] word_t;

    // command bytes from the host
    localparam byte_t CMD_LOAD      = 8'h01;
    localparam byte_t CMD_DEBUG     = 8'h02;
    localparam byte_t CMD_CONT      = 8'h04;
    localparam byte_t CMD_STEP      = 8'h08;
    localparam byte_t CMD_END_DEBUG = 8'h10;

    // program load
    localparam word_t HALT_INSTR  = 32'hffff_ffff;
    localparam int    INSTR_BYTES = 4;
    localparam word_t ADDR_STRIDE = 32'd4;
    localparam int    NB_BYTE_CNT = $clog2(INSTR_BYTES);

    // latch snapshot frames
    localparam int NB_ID_EX       = 144;
    localparam int NB_EX_MEM      = 32;
    localparam int NB_MEM_WB      = 40;
    localparam int NB_CONTROL     = 24;
    localparam int NB_SNAPSHOT    = NB_ID_EX + NB_EX_MEM + NB_MEM_WB + NB_CONTROL;
    localparam int SNAPSHOT_BYTES = NB_SNAPSHOT / NB_BYTE;   // 30
    localparam int NB_BYTE_IDX    = $clog2(SNAPSHOT_BYTES + 1);
    localparam int NB_CTRL_PAD    = 5;   // zero bits closing the control frame

    typedef logic [NB_SNAPSHOT-1:0] snapshot_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DEBUG,
        STEP,
        CONT,
        DUMP
    } ctrl_state_e;

endpackage

/* dv/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected byte k of a dump
// frames go out lsb first in the order ID_EX, EX_MEM, MEM_WB, CONTROL
function automatic byte_t expected_snapshot_byte(input int k);
    logic [NB_ID_EX-1:0]   id_ex;
    logic [NB_EX_MEM-1:0]  ex_mem;
    logic [NB_MEM_WB-1:0]  mem_wb;
    logic [NB_CONTROL-1:0] control;
    int                    base;

    id_ex   = {reg_a, reg_b, opcode, rs, rt, rd, shamt, funct, immediate, jump_addr};
    ex_mem  = alu_result;
    mem_wb  = {mem_data, mem_addr};
    control = {jump, branch, reg_dst, mem_to_reg, mem_read, mem_write, imm_flag,
               sign_flag, reg_write, alu_src, width, alu_op, fw_a, fw_b, 5'b00000};

    base = 0;
    if (k < base + NB_ID_EX / NB_BYTE) return id_ex[(k - base) * NB_BYTE +: NB_BYTE];
    base = base + NB_ID_EX / NB_BYTE;
    if (k < base + NB_EX_MEM / NB_BYTE) return ex_mem[(k - base) * NB_BYTE +: NB_BYTE];
    base = base + NB_EX_MEM / NB_BYTE;
    if (k < base + NB_MEM_WB / NB_BYTE) return mem_wb[(k - base) * NB_BYTE +: NB_BYTE];
    base = base + NB_MEM_WB / NB_BYTE;
    return control[(k - base) * NB_BYTE +: NB_BYTE];
endfunction

// address of load word n of a program
function automatic word_t expected_load_addr(input int n);
    return word_t'(n) * ADDR_STRIDE;
endfunction

`endif

/* dv/tb_debug_unit.sv */
`timescale 1ns/1ps

module tb_debug_unit;

    import debug_pkg::*;

    localparam int SEED           = 15493;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PROGRAM_WORDS  = 6;

    logic                   clk;
    logic                   rst_n;
    byte_t                  rx_data;
    logic                   rx_done;
    logic                   tx_done;
    logic                   end_run;
    word_t                  reg_a, reg_b, jump_addr, alu_result, mem_data;
    logic [NB_OPCODE-1:0]   opcode, funct;
    logic [NB_REG_ADDR-1:0] rs, rt, rd, shamt;
    logic [NB_IMM-1:0]      immediate;
    logic [NB_MEM_ADDR-1:0] mem_addr;
    logic                   jump, branch, reg_dst, mem_to_reg, mem_read, mem_write;
    logic                   imm_flag, sign_flag, reg_write;
    logic [NB_SEL-1:0]      alu_src, width, alu_op, fw_a, fw_b;

    logic                   tx_start;
    byte_t                  tx_data;
    word_t                  instruction;
    word_t                  instruction_addr;
    logic                   valid;
    logic                   step;
    logic                   start;

    byte_t                  tx_bytes[$];   // bytes seen by the transmitter model
    logic                   tx_pending;
    int                     tx_delay;
    word_t                  exp_words[$];
    word_t                  exp_addrs[$];
    int                     step_count;
    int                     err_count;
    int                     tests_run;
    int                     tests_failed;
    int                     test_errs_start;

    `include "tb_ref.svh"

    debug_unit_top UUT (
        .clk(clk), .i_rst_n(rst_n),
        .i_rx_data(rx_data), .i_rx_done(rx_done), .i_tx_done(tx_done), .i_end(end_run),
        .i_reg_a(reg_a), .i_reg_b(reg_b), .i_opcode(opcode), .i_rs(rs), .i_rt(rt),
        .i_rd(rd), .i_shamt(shamt), .i_funct(funct), .i_immediate(immediate),
        .i_jump_addr(jump_addr), .i_alu_result(alu_result), .i_mem_data(mem_data),
        .i_mem_addr(mem_addr), .i_jump(jump), .i_branch(branch), .i_reg_dst(reg_dst),
        .i_mem_to_reg(mem_to_reg), .i_mem_read(mem_read), .i_mem_write(mem_write),
        .i_imm_flag(imm_flag), .i_sign_flag(sign_flag), .i_reg_write(reg_write),
        .i_alu_src(alu_src), .i_width(width), .i_alu_op(alu_op), .i_fw_a(fw_a),
        .i_fw_b(fw_b), .o_tx_start(tx_start), .o_tx_data(tx_data),
        .o_instruction(instruction), .o_instruction_address(instruction_addr),
        .o_valid(valid), .o_step(step), .o_start(start)
    );

    always #10 clk = ~clk;

    // transmitter model, answers each start after 1 to 8 cycles
    initial begin
        tx_done    = 1'b0;
        tx_pending = 1'b0;
        tx_delay   = 0;
        forever begin
            @(negedge clk);
            tx_done = 1'b0;
            if (tx_pending) begin
                if (tx_start) begin
                    $display("error at %0t ns: o_tx_start while a byte is outstanding", $time);
                    err_count++;
                end
                if (tx_delay == 0) begin
                    tx_done    = 1'b1;
                    tx_pending = 1'b0;
                end else begin
                    tx_delay--;
                end
            end else if (tx_start) begin
                tx_bytes.push_back(tx_data);
                tx_pending = 1'b1;
                tx_delay   = $urandom_range(0, 7);
            end
        end
    end

    // compares load words and counts step pulses
    always @(negedge clk) begin
        if (rst_n && valid) begin
            if (exp_words.size() == 0) begin
                $display("error at %0t ns: o_valid with no word outstanding", $time);
                err_count++;
            end else begin
                if (instruction !== exp_words[0] || instruction_addr !== exp_addrs[0]) begin
                    $display("error at %0t ns: word %h at %h, expected %h at %h", $time,
                             instruction, instruction_addr, exp_words[0], exp_addrs[0]);
                    err_count++;
                end
                void'(exp_words.pop_front());
                void'(exp_addrs.pop_front());
            end
        end
        if (rst_n && step) begin
            step_count++;
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge clk);
        rx_data = b;
        rx_done = 1'b1;
        @(negedge clk);
        rx_done = 1'b0;
        repeat (2) @(negedge clk);   // gap between uart bytes
    endtask

    task automatic send_word(input word_t w);
        int i;
        for (i = INSTR_BYTES - 1; i >= 0; i--) begin
            send_byte(w[i*NB_BYTE +: NB_BYTE]);   // msb first
        end
    endtask

    task automatic randomize_fields();
        @(negedge clk);
        reg_a      = $urandom();
        reg_b      = $urandom();
        jump_addr  = $urandom();
        alu_result = $urandom();
        mem_data   = $urandom();
        {opcode, funct, rs, rt, rd, shamt} = 32'($urandom());
        {immediate, mem_addr}              = 24'($urandom());
        {jump, branch, reg_dst, mem_to_reg, mem_read, mem_write, imm_flag, sign_flag,
         reg_write, alu_src, width, alu_op, fw_a, fw_b} = 19'($urandom());
    endtask

    task automatic load_program(input int n);
        word_t w;
        int    i;
        int    cycles;
        send_byte(CMD_LOAD);
        for (i = 0; i < n; i++) begin
            do begin
                w = $urandom();
            end while (w == HALT_INSTR);
            exp_words.push_back(w);
            exp_addrs.push_back(expected_load_addr(i));
            send_word(w);
        end
        send_word(HALT_INSTR);   // must not raise o_valid
        cycles = 0;
        while (exp_words.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_words.size() != 0) abort_on_timeout("the loaded words");
    endtask

    task automatic wait_start(input logic level);
        int cycles;
        cycles = 0;
        while (start !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (start !== level) abort_on_timeout("o_start to change");
    endtask

    task automatic check_dump();
        byte_t exp_bytes[SNAPSHOT_BYTES];
        int    cycles;
        int    k;
        for (k = 0; k < SNAPSHOT_BYTES; k++) begin
            exp_bytes[k] = expected_snapshot_byte(k);   // fields at the dump request
        end
        cycles = 0;
        while (tx_bytes.size() == 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_bytes.size() == 0) abort_on_timeout("the first dump byte");
        randomize_fields();   // later bytes come from the snapshot
        cycles = 0;
        while ((tx_bytes.size() < SNAPSHOT_BYTES || tx_pending) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_bytes.size() < SNAPSHOT_BYTES || tx_pending) abort_on_timeout("the dump");
        repeat (5) @(negedge clk);   // controller leaves DUMP
        if (tx_bytes.size() != SNAPSHOT_BYTES) begin
            $display("error at %0t ns: %0d dump bytes, expected %0d", $time,
                     tx_bytes.size(), SNAPSHOT_BYTES);
            err_count++;
        end
        for (k = 0; k < SNAPSHOT_BYTES && k < tx_bytes.size(); k++) begin
            if (tx_bytes[k] !== exp_bytes[k]) begin
                $display("error at %0t ns: dump byte %0d is %h, expected %h", $time, k,
                         tx_bytes[k], exp_bytes[k]);
                err_count++;
            end
        end
        tx_bytes.delete();
    endtask

    task automatic dump_by_command(input byte_t cmd, input int exp_steps);
        randomize_fields();
        step_count = 0;
        send_byte(cmd);
        check_dump();
        if (step_count != exp_steps) begin
            $display("error at %0t ns: %0d step pulses, expected %0d", $time,
                     step_count, exp_steps);
            err_count++;
        end
    endtask

    task automatic check_ignored(input byte_t b);
        step_count = 0;
        send_byte(b);
        repeat (10) @(negedge clk);   // a step or a dump would have begun by now
        if (step_count != 0 || tx_bytes.size() != 0) begin
            $display("error at %0t ns: byte %h gave %0d steps and %0d dump bytes", $time,
                     b, step_count, tx_bytes.size());
            err_count++;
        end
        tx_bytes.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_errs_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_count - test_errs_start);
        end
        test_errs_start = err_count;
    endtask

    initial begin
        int i;
        void'($urandom(SEED));
        clk             = 1'b0;
        rst_n           = 1'b0;
        rx_data         = '0;
        rx_done         = 1'b0;
        end_run         = 1'b0;
        {reg_a, reg_b, jump_addr, alu_result, mem_data} = '0;
        {opcode, funct, rs, rt, rd, shamt, immediate, mem_addr} = '0;
        {jump, branch, reg_dst, mem_to_reg, mem_read, mem_write, imm_flag, sign_flag,
         reg_write, alu_src, width, alu_op, fw_a, fw_b} = '0;
        step_count      = 0;
        err_count       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        test_errs_start = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (valid || step || start || tx_start) begin
                $display("error at %0t ns: output active after reset", $time);
                err_count++;
            end
        end
        if (tx_data !== '0 || instruction_addr !== '0) begin
            $display("error at %0t ns: o_tx_data or address not cleared by reset", $time);
            err_count++;
        end
        end_test("reset");

        load_program(PROGRAM_WORDS);
        load_program(2);   // addresses restart at 0
        end_test("program load");

        randomize_fields();
        send_byte(CMD_CONT);
        wait_start(1'b1);
        end_run = 1'b1;
        wait_start(1'b0);
        end_run = 1'b0;
        check_dump();
        if (start) begin
            $display("error at %0t ns: o_start high after the dump", $time);
            err_count++;
        end
        end_test("continuous run");

        send_byte(CMD_DEBUG);
        dump_by_command(CMD_STEP, 1);
        dump_by_command(CMD_STEP, 1);   // new fields
        check_ignored(8'h55);
        end_test("debug step");

        dump_by_command(CMD_END_DEBUG, 0);
        load_program(1);   // only taken from IDLE
        end_test("end of debug");

        send_byte(CMD_DEBUG);
        for (i = 0; i < 3; i++) begin
            dump_by_command(CMD_STEP, 1);
        end
        dump_by_command(CMD_END_DEBUG, 0);
        end_test("back-pressure");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hw/debug_ctrl.sv */
`timescale 1ns/1ps

module debug_ctrl (
    input  logic             clk,
    input  logic             i_rst_n,
    input  debug_pkg::byte_t i_rx_data,
    input  logic             i_rx_done,
    input  logic             i_end,
    input  logic             i_halt,
    input  logic             i_dump_done,
    output logic             o_load_active,
    output logic             o_dump_go,
    output logic             o_step,
    output logic             o_start
);

    import debug_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        ret_debug_q;  // dump returns to DEBUG when set
    logic        ret_debug_d;
    logic        dump_go_q;
    logic        dump_go_d;

    always_comb begin
        state_d     = state_q;
        ret_debug_d = ret_debug_q;
        dump_go_d   = 1'b0;

        case (state_q)
            IDLE: begin
                if (i_rx_done) begin
                    case (i_rx_data)
                        CMD_LOAD:  state_d = LOAD;
                        CMD_DEBUG: state_d = DEBUG;
                        CMD_CONT:  state_d = CONT;
                        default:   state_d = IDLE;   // unknown byte dropped
                    endcase
                end
            end
            LOAD: begin
                if (i_halt) begin
                    state_d = IDLE;
                end
            end
            DEBUG: begin
                if (i_rx_done) begin
                    if (i_rx_data == CMD_STEP) begin
                        state_d = STEP;
                    end else if (i_rx_data == CMD_END_DEBUG) begin
                        state_d     = DUMP;   // final dump, no step
                        ret_debug_d = 1'b0;
                        dump_go_d   = 1'b1;
                    end
                end
            end
            STEP: begin
                // one clock of o_step, then request the dump
                state_d     = DUMP;
                ret_debug_d = 1'b1;
                dump_go_d   = 1'b1;
            end
            CONT: begin
                if (i_end) begin
                    state_d     = DUMP;
                    ret_debug_d = 1'b0;
                    dump_go_d   = 1'b1;
                end
            end
            DUMP: begin
                if (i_dump_done) begin
                    state_d = ret_debug_q ? DEBUG : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= IDLE;
            ret_debug_q <= 1'b0;
            dump_go_q   <= 1'b0;
        end else begin
            state_q     <= state_d;
            ret_debug_q <= ret_debug_d;
            dump_go_q   <= dump_go_d;   // first cycle of DUMP
        end
    end

    assign o_load_active = (state_q == LOAD);
    assign o_step        = (state_q == STEP);
    assign o_start       = (state_q == CONT);   // pipeline free-runs
    assign o_dump_go     = dump_go_q;

endmodule

/* hw/debug_unit_top.sv */
`timescale 1ns/1ps

module debug_unit_top (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  debug_pkg::byte_t                    i_rx_data,
    input  logic                                i_rx_done,
    input  logic                                i_tx_done,
    input  logic                                i_end,
    input  debug_pkg::word_t                    i_reg_a,
    input  debug_pkg::word_t                    i_reg_b,
    input  logic [debug_pkg::NB_OPCODE-1:0]     i_opcode,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rs,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rt,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rd,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_shamt,
    input  logic [debug_pkg::NB_OPCODE-1:0]     i_funct,
    input  logic [debug_pkg::NB_IMM-1:0]        i_immediate,
    input  debug_pkg::word_t                    i_jump_addr,
    input  debug_pkg::word_t                    i_alu_result,
    input  debug_pkg::word_t                    i_mem_data,
    input  logic [debug_pkg::NB_MEM_ADDR-1:0]   i_mem_addr,
    input  logic                                i_jump,
    input  logic                                i_branch,
    input  logic                                i_reg_dst,
    input  logic                                i_mem_to_reg,
    input  logic                                i_mem_read,
    input  logic                                i_mem_write,
    input  logic                                i_imm_flag,
    input  logic                                i_sign_flag,
    input  logic                                i_reg_write,
    input  logic [debug_pkg::NB_SEL-1:0]        i_alu_src,
    input  logic [debug_pkg::NB_SEL-1:0]        i_width,
    input  logic [debug_pkg::NB_SEL-1:0]        i_alu_op,
    input  logic [debug_pkg::NB_SEL-1:0]        i_fw_a,
    input  logic [debug_pkg::NB_SEL-1:0]        i_fw_b,
    output logic                                o_tx_start,
    output debug_pkg::byte_t                    o_tx_data,
    output debug_pkg::word_t                    o_instruction,
    output debug_pkg::word_t                    o_instruction_address,
    output logic                                o_valid,
    output logic                                o_step,
    output logic                                o_start
);

    logic load_active;  // controller in LOAD
    logic halt;         // halt word seen by loader
    logic dump_go;
    logic dump_done;

    debug_ctrl u_ctrl (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rx_data     (i_rx_data),
        .i_rx_done     (i_rx_done),
        .i_end         (i_end),
        .i_halt        (halt),
        .i_dump_done   (dump_done),
        .o_load_active (load_active),
        .o_dump_go     (dump_go),
        .o_step        (o_step),
        .o_start       (o_start)
    );

    instr_loader u_loader (
        .clk                   (clk),
        .i_rst_n               (i_rst_n),
        .i_load_active         (load_active),
        .i_rx_data             (i_rx_data),
        .i_rx_done             (i_rx_done),
        .o_instruction         (o_instruction),
        .o_instruction_address (o_instruction_address),
        .o_valid               (o_valid),
        .o_halt                (halt)
    );

    dump_serializer u_dump (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_dump_go    (dump_go),
        .i_tx_done    (i_tx_done),
        .i_reg_a      (i_reg_a),
        .i_reg_b      (i_reg_b),
        .i_opcode     (i_opcode),
        .i_rs         (i_rs),
        .i_rt         (i_rt),
        .i_rd         (i_rd),
        .i_shamt      (i_shamt),
        .i_funct      (i_funct),
        .i_immediate  (i_immediate),
        .i_jump_addr  (i_jump_addr),
        .i_alu_result (i_alu_result),
        .i_mem_data   (i_mem_data),
        .i_mem_addr   (i_mem_addr),
        .i_jump       (i_jump),
        .i_branch     (i_branch),
        .i_reg_dst    (i_reg_dst),
        .i_mem_to_reg (i_mem_to_reg),
        .i_mem_read   (i_mem_read),
        .i_mem_write  (i_mem_write),
        .i_imm_flag   (i_imm_flag),
        .i_sign_flag  (i_sign_flag),
        .i_reg_write  (i_reg_write),
        .i_alu_src    (i_alu_src),
        .i_width      (i_width),
        .i_alu_op     (i_alu_op),
        .i_fw_a       (i_fw_a),
        .i_fw_b       (i_fw_b),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data),
        .o_dump_done  (dump_done)
    );

endmodule

/* hw/dump/dump_serializer.sv */
`timescale 1ns/1ps

module dump_serializer (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_dump_go,
    input  logic                                i_tx_done,
    input  debug_pkg::word_t                    i_reg_a,
    input  debug_pkg::word_t                    i_reg_b,
    input  logic [debug_pkg::NB_OPCODE-1:0]     i_opcode,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rs,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rt,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_rd,
    input  logic [debug_pkg::NB_REG_ADDR-1:0]   i_shamt,
    input  logic [debug_pkg::NB_OPCODE-1:0]     i_funct,
    input  logic [debug_pkg::NB_IMM-1:0]        i_immediate,
    input  debug_pkg::word_t                    i_jump_addr,
    input  debug_pkg::word_t                    i_alu_result,
    input  debug_pkg::word_t                    i_mem_data,
    input  logic [debug_pkg::NB_MEM_ADDR-1:0]   i_mem_addr,
    input  logic                                i_jump,
    input  logic                                i_branch,
    input  logic                                i_reg_dst,
    input  logic                                i_mem_to_reg,
    input  logic                                i_mem_read,
    input  logic                                i_mem_write,
    input  logic                                i_imm_flag,
    input  logic                                i_sign_flag,
    input  logic                                i_reg_write,
    input  logic [debug_pkg::NB_SEL-1:0]        i_alu_src,
    input  logic [debug_pkg::NB_SEL-1:0]        i_width,
    input  logic [debug_pkg::NB_SEL-1:0]        i_alu_op,
    input  logic [debug_pkg::NB_SEL-1:0]        i_fw_a,
    input  logic [debug_pkg::NB_SEL-1:0]        i_fw_b,
    output logic                                o_tx_start,
    output debug_pkg::byte_t                    o_tx_data,
    output logic                                o_dump_done
);

    import debug_pkg::*;

    logic [NB_ID_EX-1:0]    id_ex_frame;
    logic [NB_EX_MEM-1:0]   ex_mem_frame;
    logic [NB_MEM_WB-1:0]   mem_wb_frame;
    logic [NB_CONTROL-1:0]  control_frame;
    snapshot_t              snap_d;
    snapshot_t              snap_q;
    logic [NB_BYTE_IDX-1:0] idx_q;   // next byte to send
    logic                   busy_q;

    assign id_ex_frame   = {i_reg_a, i_reg_b, i_opcode, i_rs, i_rt, i_rd,
                            i_shamt, i_funct, i_immediate, i_jump_addr};
    assign ex_mem_frame  = i_alu_result;
    assign mem_wb_frame  = {i_mem_data, i_mem_addr};
    assign control_frame = {i_jump, i_branch, i_reg_dst, i_mem_to_reg, i_mem_read,
                            i_mem_write, i_imm_flag, i_sign_flag, i_reg_write,
                            i_alu_src, i_width, i_alu_op, i_fw_a, i_fw_b,
                            {NB_CTRL_PAD{1'b0}}};

    // ID_EX in the low bytes so it leaves first
    assign snap_d = {control_frame, mem_wb_frame, ex_mem_frame, id_ex_frame};

    always_ff @(posedge clk) begin
        if (i_dump_go) begin
            snap_q <= snap_d;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q      <= 1'b0;
            idx_q       <= '0;
            o_tx_start  <= 1'b0;
            o_tx_data   <= '0;
            o_dump_done <= 1'b0;
        end else begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;

            if (i_dump_go) begin
                // byte 0 straight from the live fields, snap_q not loaded yet
                busy_q     <= 1'b1;
                idx_q      <= NB_BYTE_IDX'(1);
                o_tx_start <= 1'b1;
                o_tx_data  <= snap_d[NB_BYTE-1:0];
            end else if (busy_q && i_tx_done) begin
                if (idx_q == NB_BYTE_IDX'(SNAPSHOT_BYTES)) begin
                    busy_q      <= 1'b0;   // last byte acknowledged
                    o_dump_done <= 1'b1;
                end else begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= snap_q[idx_q*NB_BYTE +: NB_BYTE];
                    idx_q      <= idx_q + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/loader/instr_loader.sv */
`timescale 1ns/1ps

module instr_loader (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_load_active,
    input  debug_pkg::byte_t i_rx_data,
    input  logic             i_rx_done,
    output debug_pkg::word_t o_instruction,
    output debug_pkg::word_t o_instruction_address,
    output logic             o_valid,
    output logic             o_halt
);

    import debug_pkg::*;

    logic [NB_BYTE_CNT-1:0] byte_cnt_q;
    logic                   load_active_q;
    logic                   load_rise;
    logic                   last_byte;
    word_t                  shift_q;
    word_t                  word_next;   // word including the current byte
    word_t                  addr_q;

    assign load_rise = i_load_active & ~load_active_q;
    assign last_byte = (byte_cnt_q == NB_BYTE_CNT'(INSTR_BYTES - 1));
    assign word_next = {shift_q[NB_WORD-NB_BYTE-1:0], i_rx_data};   // msb first on the line

    always_ff @(posedge clk) begin
        if (i_load_active && i_rx_done) begin
            shift_q <= word_next;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_active_q <= 1'b0;
            byte_cnt_q    <= '0;
            o_valid       <= 1'b0;
            o_halt        <= 1'b0;
            addr_q        <= '0;
        end else begin
            load_active_q <= i_load_active;
            o_valid       <= 1'b0;
            o_halt        <= 1'b0;

            if (!i_load_active) begin
                byte_cnt_q <= '0;   // drop any partial word
            end else if (i_rx_done) begin
                if (last_byte) begin
                    byte_cnt_q <= '0;
                    if (word_next == HALT_INSTR) begin
                        o_halt <= 1'b1;
                    end else begin
                        o_valid <= 1'b1;
                    end
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end

            if (load_rise) begin
                addr_q <= '0;   // new program starts at 0
            end else if (o_valid) begin
                addr_q <= addr_q + ADDR_STRIDE;   // after the word is taken
            end
        end
    end

    assign o_instruction         = shift_q;
    assign o_instruction_address = addr_q;

endmodule

/* src.f */
+incdir+dv
common/debug_pkg.sv
hw/loader/instr_loader.sv
hw/dump/dump_serializer.sv
hw/debug_ctrl.sv
hw/debug_unit_top.sv
dv/tb_debug_unit.sv
